// ==== goose_render.f ====
+incdir+verilog
verilog/goose_render_pkg.sv
verilog/goose_sprite.sv
verilog/obstacle_shield.sv
verilog/backdrop.sv
verilog/layer_compositor.sv
verilog/goose_render.sv
tb/goose_render_tb.sv

// ==== tb/goose_render_tb.sv ====
//######################################
// Directed testbench for the goose renderer
// Drives raster pixels on the falling edge and checks colour
// and collision one cycle later
//######################################

`timescale 1ns/1ps

`include "goose_render_defs.svh"

module goose_render_tb;

    // Tests take under 250 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    // Palette as {r, g, b}
    localparam logic [5:0] BODY  = {2'd2, 2'd2, 2'd1};
    localparam logic [5:0] BLACK = {2'd0, 2'd0, 2'd0};
    localparam logic [5:0] BEAK  = {2'd3, 2'd2, 2'd1};
    localparam logic [5:0] GOLD  = {2'd3, 2'd2, 2'd0};
    localparam logic [5:0] WHITE = {2'd3, 2'd3, 2'd3};
    localparam logic [5:0] RED   = {2'd2, 2'd0, 2'd0};
    localparam logic [5:0] SKY   = {2'd0, 2'd3, 2'd3};
    localparam logic [5:0] FLOOR = {2'd1, 2'd1, 2'd1};
    localparam logic [5:0] DOT   = {2'd2, 2'd2, 2'd2};

    logic        clk;
    logic        sys_rst;
    logic [9:0]  hpos;
    logic [9:0]  vpos;
    logic [10:0] scroll;
    logic        display_on;
    logic [6:0]  jump_pos;
    logic        goose_visible;
    logic        game_over;
    logic        obstacle_active;
    logic [1:0]  r;
    logic [1:0]  g;
    logic [1:0]  b;
    logic        collision;

    integer seed = 70390;
    integer error_count = 0;
    integer check_count = 0;
    integer cycle_count;

    goose_render u_dut (
        .clk             (clk),
        .sys_rst         (sys_rst),
        .hpos            (hpos),
        .vpos            (vpos),
        .scroll          (scroll),
        .display_on      (display_on),
        .jump_pos        (jump_pos),
        .goose_visible   (goose_visible),
        .game_over       (game_over),
        .obstacle_active (obstacle_active),
        .r               (r),
        .g               (g),
        .b               (b),
        .collision       (collision)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Backdrop colour from the sky, floor and dot rules
    function automatic logic [5:0] scenery_colour(input logic [9:0] h, input logic [9:0] v,
                                                  input logic [10:0] s);
        logic [3:0] phase;
        phase = h[3:0] + s[3:0];
        if (v < 10'd240) begin
            scenery_colour = SKY;
        end
        else if ((v == 10'd240) && (phase >= 4'd2) && (phase <= 4'd5)) begin
            scenery_colour = DOT;
        end
        else begin
            scenery_colour = FLOOR;
        end
    endfunction

    // Called on a falling edge; result shows at the next one
    task automatic expect_pixel(input string name, input logic [9:0] h, input logic [9:0] v,
                                input logic [5:0] exp_rgb, input logic exp_col);
        hpos = h;
        vpos = v;
        @(negedge clk);
        check_count = check_count + 1;
        if ({r, g, b, collision} !== {exp_rgb, exp_col}) begin
            error_count = error_count + 1;
            $write("Mismatch %s at (%0d,%0d): expected rgb=%0d,%0d,%0d col=%0d",
                   name, h, v, exp_rgb[5:4], exp_rgb[3:2], exp_rgb[1:0], exp_col);
            $display(", actual rgb=%0d,%0d,%0d col=%0d", r, g, b, collision);
        end
    endtask

    task automatic reset_and_blanking();
        // Overlap pixel with the display on, so only reset holds the output low
        sys_rst = 1'b1;
        display_on = 1'b1;
        scroll = 11'd830;
        goose_visible = 1'b1;
        obstacle_active = 1'b1;
        expect_pixel("reset", 10'd76, 10'd232, BLACK, 1'b0);
        sys_rst = 1'b0;
        display_on = 1'b0;
        expect_pixel("reset_release", 10'd100, 10'd100, BLACK, 1'b0);
        // Shield over the goose, but the display is off
        expect_pixel("blank_overlap", 10'd76, 10'd232, BLACK, 1'b0);
        expect_pixel("blank_shield", 10'd62, 10'd232, BLACK, 1'b0);
        expect_pixel("blank_sky", 10'd400, 10'd50, BLACK, 1'b0);
        display_on = 1'b1;
        goose_visible = 1'b0;
        obstacle_active = 1'b0;
    endtask

    task automatic backdrop_layer();
        integer i;
        integer k;
        logic [9:0] h;
        scroll = 11'd0;
        for (i = 0; i < 8; i = i + 1) begin
            h = {$random(seed)} % 640;
            expect_pixel("sky", h, 10'd100, SKY, 1'b0);
            expect_pixel("floor", h, 10'd300, FLOOR, 1'b0);
        end
        for (k = 0; k < 4; k = k + 1) begin
            scroll = $random(seed);
            for (i = 0; i < 16; i = i + 1) begin
                h = 10'd100 + i;
                expect_pixel("floor_dots", h, 10'd240, scenery_colour(h, 10'd240, scroll), 1'b0);
            end
        end
    endtask

    task automatic goose_layer();
        scroll = 11'd0;
        jump_pos = 7'd0;
        goose_visible = 1'b1;
        // ROM pixel (row, col) sits at (GOOSE_X + 2*col, GOOSE_Y_BASE + 2*row)
        expect_pixel("goose_body", `GOOSE_X + 12, `GOOSE_Y_BASE + 24, BODY, 1'b0);
        expect_pixel("goose_neck", `GOOSE_X + 24, `GOOSE_Y_BASE + 4, BLACK, 1'b0);
        expect_pixel("goose_beak", `GOOSE_X + 30, `GOOSE_Y_BASE + 8, BEAK, 1'b0);
        expect_pixel("goose_row0", `GOOSE_X + 16, `GOOSE_Y_BASE, SKY, 1'b0);
        jump_pos = 7'd20;
        expect_pixel("jump_body", `GOOSE_X + 12, `GOOSE_Y_BASE + 4, BODY, 1'b0);
        expect_pixel("jump_old_spot", `GOOSE_X + 12, `GOOSE_Y_BASE + 24, SKY, 1'b0);
        jump_pos = 7'd0;
        goose_visible = 1'b0;
        expect_pixel("blink_off", `GOOSE_X + 12, `GOOSE_Y_BASE + 24, SKY, 1'b0);
        goose_visible = 1'b1;
        game_over = 1'b1;
        expect_pixel("over_body", `GOOSE_X + 12, `GOOSE_Y_BASE + 24, RED, 1'b0);
        expect_pixel("over_neck", `GOOSE_X + 24, `GOOSE_Y_BASE + 4, RED, 1'b0);
        expect_pixel("over_beak", `GOOSE_X + 30, `GOOSE_Y_BASE + 8, RED, 1'b0);
        expect_pixel("over_row0", `GOOSE_X + 16, `GOOSE_Y_BASE, SKY, 1'b0);
        game_over = 1'b0;
        goose_visible = 1'b0;
    endtask

    task automatic shield_layer();
        // Left edge 640 - 590 + 250 = 300, rows 192 to 239
        scroll = 11'd590;
        obstacle_active = 1'b1;
        expect_pixel("outer_left", 10'd300, 10'd210, BLACK, 1'b0);
        expect_pixel("outer_right", 10'd339, 10'd210, BLACK, 1'b0);
        expect_pixel("outer_top", 10'd320, 10'd192, BLACK, 1'b0);
        expect_pixel("outer_bottom", 10'd320, 10'd239, BLACK, 1'b0);
        expect_pixel("inner_left", 10'd301, 10'd210, WHITE, 1'b0);
        expect_pixel("inner_right", 10'd338, 10'd210, WHITE, 1'b0);
        expect_pixel("inner_top", 10'd320, 10'd193, WHITE, 1'b0);
        expect_pixel("inner_bottom", 10'd320, 10'd238, WHITE, 1'b0);
        expect_pixel("fill", 10'd320, 10'd215, GOLD, 1'b0);
        expect_pixel("left_of_box", 10'd299, 10'd210, SKY, 1'b0);
        expect_pixel("right_of_box", 10'd340, 10'd210, SKY, 1'b0);
        expect_pixel("above_box", 10'd320, 10'd191, SKY, 1'b0);
        expect_pixel("below_box", 10'd320, 10'd240, scenery_colour(10'd320, 10'd240, scroll), 1'b0);
        obstacle_active = 1'b0;
        expect_pixel("shield_off", 10'd320, 10'd215, SKY, 1'b0);
    endtask

    task automatic collision_priority();
        // Left edge 640 - 830 + 250 = 60, so the shield covers the goose
        scroll = 11'd830;
        obstacle_active = 1'b1;
        goose_visible = 1'b1;
        jump_pos = 7'd0;
        expect_pixel("overlap_body", 10'd76, 10'd232, BODY, 1'b1);
        expect_pixel("overlap_neck", 10'd88, 10'd212, BLACK, 1'b1);
        expect_pixel("shield_only", 10'd62, 10'd232, GOLD, 1'b0);
        expect_pixel("goose_row0_shield", 10'd80, 10'd208, GOLD, 1'b0);
        obstacle_active = 1'b0;
        goose_visible = 1'b0;
    endtask

    initial begin
        sys_rst = 1'b1;
        hpos = 10'd0;
        vpos = 10'd0;
        scroll = 11'd0;
        display_on = 1'b0;
        jump_pos = 7'd0;
        goose_visible = 1'b0;
        game_over = 1'b0;
        obstacle_active = 1'b0;
        @(negedge clk);
        reset_and_blanking();
        backdrop_layer();
        goose_layer();
        shield_layer();
        collision_priority();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end
        else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== verilog/backdrop.sv ====
//######################################
// Backdrop layer
// Sky above the floor line, floor below, and a dotted
// line on the first floor row that scrolls with the game
//######################################

`timescale 1ns/1ps

`include "goose_render_defs.svh"

module backdrop (
    input  logic [9:0]                 hpos,
    input  logic [9:0]                 vpos,
    input  logic [10:0]                scroll,
    output goose_render_pkg::pix_src_e bg_src
);
    import goose_render_pkg::*;

    logic [`POS_W-1:0] vpos_ext;
    logic [`POS_W-1:0] dot_pos;
    logic              in_dot;

    assign vpos_ext = {1'b0, vpos};

    // Dots repeat every 16 pixels of world position
    assign dot_pos = {1'b0, hpos} + scroll;
    assign in_dot = (dot_pos[3:0] >= `DOT_FIRST) && (dot_pos[3:0] <= `DOT_LAST);

    always_comb begin
        if (vpos_ext < `FLOOR_Y) begin
            bg_src = src_sky;
        end
        else if ((vpos_ext == `FLOOR_Y) && in_dot) begin
            bg_src = src_floor_dot;
        end
        else begin
            bg_src = src_floor;
        end
    end

endmodule

// ==== verilog/goose_render.sv ====
//######################################
// Goose game pixel renderer, top level
// Raster position and game status in, one pixel per clk,
// colour and collision out one cycle later
//######################################

`timescale 1ns/1ps

module goose_render (
    input  logic                       clk,
    input  logic                       sys_rst,
    input  logic [9:0]                 hpos,
    input  logic [9:0]                 vpos,
    input  logic [10:0]                scroll,
    input  logic                       display_on,
    input  logic [6:0]                 jump_pos,
    input  logic                       goose_visible,
    input  logic                       game_over,
    input  logic                       obstacle_active,
    output goose_render_pkg::channel_t r,
    output goose_render_pkg::channel_t g,
    output goose_render_pkg::channel_t b,
    output logic                       collision
);
    import goose_render_pkg::*;

    color_idx_e goose_idx;
    color_idx_e shield_idx;
    pix_src_e   bg_src;

    goose_sprite u_goose_sprite (
        .hpos          (hpos),
        .vpos          (vpos),
        .jump_pos      (jump_pos),
        .goose_visible (goose_visible),
        .game_over     (game_over),
        .goose_idx     (goose_idx)
    );

    obstacle_shield u_obstacle_shield (
        .hpos            (hpos),
        .vpos            (vpos),
        .scroll          (scroll),
        .obstacle_active (obstacle_active),
        .shield_idx      (shield_idx)
    );

    backdrop u_backdrop (
        .hpos   (hpos),
        .vpos   (vpos),
        .scroll (scroll),
        .bg_src (bg_src)
    );

    layer_compositor u_layer_compositor (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .display_on (display_on),
        .goose_idx  (goose_idx),
        .shield_idx (shield_idx),
        .bg_src     (bg_src),
        .r          (r),
        .g          (g),
        .b          (b),
        .collision  (collision)
    );

endmodule

// ==== verilog/goose_render_defs.svh ====
//######################################
// Screen, floor, goose and shield geometry for the renderer
// Include in any block that places or sizes a layer
//######################################

`ifndef GOOSE_RENDER_DEFS_SVH
`define GOOSE_RENDER_DEFS_SVH

// Width of all position arithmetic
`define POS_W 11

// Visible width and first floor line
`define SCREEN_W 11'd640
`define FLOOR_Y 11'd240

// Goose is 16x16 in ROM, drawn at double size
`define GOOSE_X 11'd64
`define GOOSE_SIZE 11'd32
`define GOOSE_Y_BASE (`FLOOR_Y - `GOOSE_SIZE)

// Shield stands on the floor
`define SHIELD_W 11'd40
`define SHIELD_H 11'd48
`define SHIELD_TOP (`FLOOR_Y - `SHIELD_H)

// Added to the wrapped scroll position to place the shield
`define SHIELD_OFFSET 11'd250

// Dot band inside each 16 pixel period of the floor line
`define DOT_FIRST 4'd2
`define DOT_LAST 4'd5

`endif

// ==== verilog/goose_render_pkg.sv ====
//######################################
// Shared types of the goose renderer
// Colour indices of the sprite layers and backdrop pixel classes
//######################################

package goose_render_pkg;

    // One channel of the 2-bit-per-channel output
    typedef logic [1:0] channel_t;

    // Palette index used by the goose ROM and the shield
    typedef enum logic [2:0] {
        color_transparent = 3'd0,
        color_goose_body  = 3'd1,
        color_black       = 3'd2,
        color_beak        = 3'd3,
        color_gold        = 3'd4,
        color_white       = 3'd5,
        color_red         = 3'd6
    } color_idx_e;

    // Class of the backdrop pixel under the sprites
    typedef enum logic [1:0] {
        src_none      = 2'd0,
        src_sky       = 2'd1,
        src_floor     = 2'd2,
        src_floor_dot = 2'd3
    } pix_src_e;

endpackage

// ==== verilog/goose_sprite.sv ====
//######################################
// Goose sprite layer
// Bounds test, ROM lookup at double size, blink gate and
// the red tint shown at game over
//######################################

`timescale 1ns/1ps

`include "goose_render_defs.svh"

module goose_sprite (
    input  logic [9:0]                   hpos,
    input  logic [9:0]                   vpos,
    input  logic [6:0]                   jump_pos,
    input  logic                         goose_visible,
    input  logic                         game_over,
    output goose_render_pkg::color_idx_e goose_idx
);
    import goose_render_pkg::*;

    logic [`POS_W-1:0] goose_y;
    logic [`POS_W-1:0] dx;
    logic [`POS_W-1:0] dy;
    logic              in_box;
    logic [3:0]        rom_row;
    logic [3:0]        rom_col;
    logic [47:0]       row_bits;
    logic [5:0]        bit_msb;
    color_idx_e        raw_idx;

    // One ROM row, 3 bits per pixel, column 0 in the top bits
    function automatic logic [47:0] goose_rom(input logic [3:0] row);
        case (row)
            4'd0:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_000_000_000_000_000_000;
            4'd1:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_000_000_000_000_000_000;
            4'd2:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_000;
            4'd3:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011;
            4'd4:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011;
            4'd5:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011;
            4'd6:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000;
            4'd7:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000;
            4'd8:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000;
            4'd9:  goose_rom = 48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000;
            4'd10: goose_rom = 48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000;
            4'd11: goose_rom = 48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000;
            4'd12: goose_rom = 48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000;
            4'd13: goose_rom = 48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000;
            4'd14: goose_rom = 48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000;
            4'd15: goose_rom = 48'b000_000_000_000_010_010_000_000_000_010_010_000_000_000_000_000;
            default: goose_rom = '0;
        endcase
    endfunction

    // Jump lifts the goose off its standing line
    assign goose_y = `GOOSE_Y_BASE - {4'd0, jump_pos};

    // Offsets wrap to large values left of or above the box
    assign dx = {1'b0, hpos} - `GOOSE_X;
    assign dy = {1'b0, vpos} - goose_y;
    assign in_box = (dx < `GOOSE_SIZE) && (dy < `GOOSE_SIZE);

    // Each ROM pixel covers 2x2 screen pixels
    assign rom_row = dy[4:1];
    assign rom_col = dx[4:1];

    assign row_bits = goose_rom(rom_row);
    assign bit_msb = 6'd47 - (6'd3 * {2'b00, rom_col});
    assign raw_idx = color_idx_e'(row_bits[bit_msb -: 3]);

    always_comb begin
        if (!in_box || !goose_visible) begin
            goose_idx = color_transparent;
        end
        else if (game_over && (raw_idx != color_transparent)) begin
            goose_idx = color_red;
        end
        else begin
            goose_idx = raw_idx;
        end
    end

endmodule

// ==== verilog/layer_compositor.sv ====
//######################################
// Layer compositor
// Picks the top layer, maps it through the palette, blanks
// outside the display area and flags goose/shield overlap
// One register stage
//######################################

`timescale 1ns/1ps

module layer_compositor (
    input  logic                         clk,
    input  logic                         sys_rst,
    input  logic                         display_on,
    input  goose_render_pkg::color_idx_e goose_idx,
    input  goose_render_pkg::color_idx_e shield_idx,
    input  goose_render_pkg::pix_src_e   bg_src,
    output goose_render_pkg::channel_t   r,
    output goose_render_pkg::channel_t   g,
    output goose_render_pkg::channel_t   b,
    output logic                         collision
);
    import goose_render_pkg::*;

    logic [5:0] rgb_next;
    logic       hit_next;

    // Sprite palette as {r, g, b}
    function automatic logic [5:0] sprite_rgb(input color_idx_e idx);
        case (idx)
            color_goose_body: sprite_rgb = {2'd2, 2'd2, 2'd1};
            color_black:      sprite_rgb = {2'd0, 2'd0, 2'd0};
            color_beak:       sprite_rgb = {2'd3, 2'd2, 2'd1};
            color_gold:       sprite_rgb = {2'd3, 2'd2, 2'd0};
            color_white:      sprite_rgb = {2'd3, 2'd3, 2'd3};
            color_red:        sprite_rgb = {2'd2, 2'd0, 2'd0};
            default:          sprite_rgb = 6'd0;
        endcase
    endfunction

    function automatic logic [5:0] backdrop_rgb(input pix_src_e src);
        case (src)
            src_sky:       backdrop_rgb = {2'd0, 2'd3, 2'd3};
            src_floor:     backdrop_rgb = {2'd1, 2'd1, 2'd1};
            src_floor_dot: backdrop_rgb = {2'd2, 2'd2, 2'd2};
            default:       backdrop_rgb = 6'd0;
        endcase
    endfunction

    // Goose over shield over backdrop
    always_comb begin
        hit_next = (goose_idx != color_transparent) && (shield_idx != color_transparent);
        if (goose_idx != color_transparent) begin
            rgb_next = sprite_rgb(goose_idx);
        end
        else if (shield_idx != color_transparent) begin
            rgb_next = sprite_rgb(shield_idx);
        end
        else begin
            rgb_next = backdrop_rgb(bg_src);
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst || !display_on) begin
            {r, g, b} <= 6'd0;
            collision <= 1'b0;
        end
        else begin
            {r, g, b} <= rgb_next;
            collision <= hit_next;
        end
    end

    // A blanked pixel never reports a hit one cycle later
    collision_blanked: assert property (
        @(posedge clk) disable iff (sys_rst)
        !$past(display_on) |-> !collision
    ) else $error("layer_compositor: collision after blanked pixel");

    // Shield layer paints only its ring and fill colours
    shield_idx_legal: assert property (
        @(posedge clk) disable iff (sys_rst)
        (shield_idx == color_transparent) || (shield_idx == color_black) ||
        (shield_idx == color_white) || (shield_idx == color_gold)
    ) else $error("layer_compositor: illegal shield colour index %0d", shield_idx);

endmodule

// ==== verilog/obstacle_shield.sv ====
//######################################
// Scrolling shield obstacle layer
// A 40x48 box with black and white rings round a gold fill
//######################################

`timescale 1ns/1ps

`include "goose_render_defs.svh"

module obstacle_shield (
    input  logic [9:0]                   hpos,
    input  logic [9:0]                   vpos,
    input  logic [10:0]                  scroll,
    input  logic                         obstacle_active,
    output goose_render_pkg::color_idx_e shield_idx
);
    import goose_render_pkg::*;

    logic [`POS_W-1:0] shield_x;
    logic [`POS_W-1:0] vpos_ext;
    logic [`POS_W-1:0] local_x;
    logic [`POS_W-1:0] local_y;
    logic              in_x;
    logic              in_y;
    logic              outer_ring;
    logic              inner_ring;

    // Left edge moves left as scroll grows, wrapping mod 2048
    assign shield_x = `SCREEN_W - scroll + `SHIELD_OFFSET;

    assign vpos_ext = {1'b0, vpos};
    assign local_x = {1'b0, hpos} - shield_x;
    assign local_y = vpos_ext - `SHIELD_TOP;

    // Modular offset keeps a shield straddling the wrap point whole
    assign in_x = local_x < `SHIELD_W;
    assign in_y = (vpos_ext >= `SHIELD_TOP) && (vpos_ext < `FLOOR_Y);

    assign outer_ring = (local_x == 11'd0) ||
                        (local_x == `SHIELD_W - 11'd1) ||
                        (local_y == 11'd0) ||
                        (local_y == `SHIELD_H - 11'd1);

    assign inner_ring = (local_x == 11'd1) ||
                        (local_x == `SHIELD_W - 11'd2) ||
                        (local_y == 11'd1) ||
                        (local_y == `SHIELD_H - 11'd2);

    always_comb begin
        if (!obstacle_active || !in_x || !in_y) begin
            shield_idx = color_transparent;
        end
        else if (outer_ring) begin
            shield_idx = color_black;
        end
        else if (inner_ring) begin
            shield_idx = color_white;
        end
        else begin
            shield_idx = color_gold;
        end
    end

endmodule
